//--- Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - common
    files:
      - common/id_pkg.sv
      - common/ctrl_if.sv
      - source/reg_file.sv
      - decode/ctrl_decoder.sv
      - decode/branch_unit.sv
      - source/id_ex_reg.sv
      - source/id_stage.sv
  - target: test
    include_dirs:
      - common
      - dv
    files:
      - dv/id_stage_tb.sv

//--- common/ctrl_if.sv
interface ctrl_if;

    logic               reg_dst;
    logic               mem_to_reg;
    logic               mem_read;
    logic               mem_write;
    logic               imm_sign;
    logic               reg_write;
    id_pkg::alu_src_t   alu_src;
    id_pkg::alu_op_t    alu_op;
    logic               branch;
    logic               branch_ne;
    logic               jump;
    logic               jump_reg;
    logic               link;
    // extended immediate
    id_pkg::data_t      imm;

    modport decoder (
        output reg_dst, mem_to_reg, mem_read, mem_write, imm_sign, reg_write,
        output alu_src, alu_op, branch, branch_ne, jump, jump_reg, link, imm
    );

    modport resolver (
        input jump, jump_reg, branch, branch_ne, link, imm
    );

    modport pipe (
        input reg_dst, mem_to_reg, mem_read, mem_write, imm_sign, reg_write,
        input alu_src, alu_op, branch, link, imm
    );

endinterface

//--- common/id_pkg.sv
package id_pkg;

    `include "id_settings.svh"

    // register, pc or immediate word
    typedef logic [`ID_DATA_W-1:0]     data_t;
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

    // instruction fields
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] target_t;

    // second alu operand select
    typedef logic [1:0] alu_src_t;

    localparam alu_src_t ALU_SRC_REG  = 2'd0;
    localparam alu_src_t ALU_SRC_IMM  = 2'd1;
    localparam alu_src_t ALU_SRC_LINK = 2'd2;

    // alu operation class, funct decides for r-type
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALU_OP_ADD   = 2'd0;
    localparam alu_op_t ALU_OP_SUB   = 2'd1;
    localparam alu_op_t ALU_OP_FUNCT = 2'd2;
    localparam alu_op_t ALU_OP_OR    = 2'd3;

    // what kind of control transfer the fetch stage sees
    typedef logic [1:0] jump_case_t;

    localparam jump_case_t JUMP_CASE_NONE   = 2'd0;
    localparam jump_case_t JUMP_CASE_BRANCH = 2'd1;
    localparam jump_case_t JUMP_CASE_LINK   = 2'd2;

endpackage

//--- common/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

`define ID_DATA_W       32
`define ID_REG_ADDR_W   5
`define ID_NUM_REGS     32
`define ID_LINK_REG     5'd31
`define ID_LINK_OFFSET  32'd4
`define ID_HALT_WORD    32'hFFFF_FFFF

// opcodes
`define ID_OPC_RTYPE    6'd0
`define ID_OPC_J        6'd2
`define ID_OPC_JAL      6'd3
`define ID_OPC_BEQ      6'd4
`define ID_OPC_BNE      6'd5
`define ID_OPC_ADDI     6'd8
`define ID_OPC_ORI      6'd13
`define ID_OPC_LW       6'd35
`define ID_OPC_SW       6'd43

// funct codes under R-type
`define ID_FN_JR        6'd8
`define ID_FN_JALR      6'd9

`endif

//--- decode/branch_unit.sv
`include "id_settings.svh"

module branch_unit (
    input  id_pkg::data_t       i_pcounter4,
    input  id_pkg::target_t     i_target,
    input  id_pkg::data_t       i_rs_data,
    input  id_pkg::data_t       i_rt_data,
    ctrl_if.resolver            ctrl,
    output logic                o_jump,
    output id_pkg::jump_case_t  o_jump_cases,
    output id_pkg::data_t       o_addr2jump
);

    logic          regs_equal;
    logic          branch_taken;
    id_pkg::data_t jump_target;
    id_pkg::data_t branch_target;

    assign regs_equal   = (i_rs_data == i_rt_data);
    assign branch_taken = ctrl.branch && (ctrl.branch_ne ? !regs_equal : regs_equal);

    // pseudo-direct jump inside the current 256MB region
    assign jump_target = {i_pcounter4[`ID_DATA_W-1:`ID_DATA_W-4], i_target, 2'b00};

    // offset counts from one word past pc4
    assign branch_target = i_pcounter4 + `ID_DATA_W'd4 + (ctrl.imm << 2);

    always_comb begin
        o_jump      = 1'b0;
        o_addr2jump = '0;
        if (ctrl.jump_reg) begin
            o_jump      = 1'b1;
            o_addr2jump = i_rs_data;
        end else if (ctrl.jump) begin
            o_jump      = 1'b1;
            o_addr2jump = jump_target;
        end else if (branch_taken) begin
            o_jump      = 1'b1;
            o_addr2jump = branch_target;
        end
    end

    always_comb begin
        if (ctrl.branch) begin
            o_jump_cases = id_pkg::JUMP_CASE_BRANCH;
        end else if (ctrl.link) begin
            o_jump_cases = id_pkg::JUMP_CASE_LINK;
        end else begin
            o_jump_cases = id_pkg::JUMP_CASE_NONE;
        end
    end

endmodule

//--- decode/ctrl_decoder.sv
`include "id_settings.svh"

module ctrl_decoder (
    input  id_pkg::opcode_t i_opcode,
    input  id_pkg::funct_t  i_funct,
    input  id_pkg::imm16_t  i_imm,
    ctrl_if.decoder         ctrl
);

    always_comb begin
        ctrl.reg_dst    = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.imm_sign   = 1'b1;
        ctrl.reg_write  = 1'b0;
        ctrl.alu_src    = id_pkg::ALU_SRC_REG;
        ctrl.alu_op     = id_pkg::ALU_OP_ADD;
        ctrl.branch     = 1'b0;
        ctrl.branch_ne  = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.jump_reg   = 1'b0;
        ctrl.link       = 1'b0;

        case (i_opcode)
            `ID_OPC_RTYPE: begin
                if (i_funct == `ID_FN_JR) begin
                    ctrl.jump     = 1'b1;
                    ctrl.jump_reg = 1'b1;
                end else if (i_funct == `ID_FN_JALR) begin
                    // link into rd
                    ctrl.jump      = 1'b1;
                    ctrl.jump_reg  = 1'b1;
                    ctrl.link      = 1'b1;
                    ctrl.reg_dst   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = id_pkg::ALU_SRC_LINK;
                end else begin
                    ctrl.reg_dst   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = id_pkg::ALU_OP_FUNCT;
                end
            end
            `ID_OPC_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = id_pkg::ALU_SRC_LINK;
            end
            `ID_OPC_J: begin
                ctrl.jump = 1'b1;
            end
            `ID_OPC_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = id_pkg::ALU_SRC_IMM;
            end
            `ID_OPC_ORI: begin
                // logical op takes zero-extended immediate
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = id_pkg::ALU_SRC_IMM;
                ctrl.alu_op    = id_pkg::ALU_OP_OR;
                ctrl.imm_sign  = 1'b0;
            end
            `ID_OPC_LW: begin
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = id_pkg::ALU_SRC_IMM;
            end
            `ID_OPC_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = id_pkg::ALU_SRC_IMM;
            end
            `ID_OPC_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = id_pkg::ALU_OP_SUB;
            end
            `ID_OPC_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_OP_SUB;
            end
            default: begin
            end
        endcase
    end

    assign ctrl.imm = ctrl.imm_sign ? {{(`ID_DATA_W-16){i_imm[15]}}, i_imm}
                                    : {{(`ID_DATA_W-16){1'b0}}, i_imm};

endmodule

//--- dv/id_stage_model.svh
`ifndef ID_STAGE_MODEL_SVH
`define ID_STAGE_MODEL_SVH

// expected decoder flags for one instruction
typedef struct packed {
    logic              reg_dst;
    logic              mem_to_reg;
    logic              mem_read;
    logic              mem_write;
    logic              imm_sign;
    logic              reg_write;
    logic              branch;
    logic              branch_ne;
    logic              jump;
    logic              jump_reg;
    logic              link;
    id_pkg::alu_src_t  alu_src;
    id_pkg::alu_op_t   alu_op;
} ctl_ref_t;

// register mirror, updated one edge after the write is driven
id_pkg::data_t mirror [`ID_NUM_REGS];

function automatic ctl_ref_t decode_ref(id_pkg::opcode_t op, id_pkg::funct_t fn);
    ctl_ref_t c;
    c = '0;
    c.imm_sign = (op != `ID_OPC_ORI);
    case (op)
        `ID_OPC_RTYPE: begin
            c.jump     = (fn == `ID_FN_JR) || (fn == `ID_FN_JALR);
            c.jump_reg = c.jump;
            c.link     = (fn == `ID_FN_JALR);
            c.reg_dst  = !c.jump || c.link;
            c.reg_write = c.reg_dst;
            c.alu_src  = c.link ? 2'd2 : 2'd0;
            c.alu_op   = c.jump ? 2'd0 : 2'd2;
        end
        `ID_OPC_JAL: begin
            c.jump      = 1'b1;
            c.link      = 1'b1;
            c.reg_write = 1'b1;
            c.alu_src   = 2'd2;
        end
        `ID_OPC_J:    c.jump = 1'b1;
        `ID_OPC_ADDI: {c.reg_write, c.alu_src} = {1'b1, 2'd1};
        `ID_OPC_ORI:  {c.reg_write, c.alu_src, c.alu_op} = {1'b1, 2'd1, 2'd3};
        `ID_OPC_LW:   {c.mem_read, c.mem_to_reg, c.reg_write, c.alu_src} = {3'b111, 2'd1};
        `ID_OPC_SW:   {c.mem_write, c.alu_src} = {1'b1, 2'd1};
        `ID_OPC_BEQ:  {c.branch, c.alu_op} = {1'b1, 2'd1};
        `ID_OPC_BNE:  {c.branch, c.branch_ne, c.alu_op} = {2'b11, 2'd1};
        default: begin
        end
    endcase
    return c;
endfunction

function automatic id_pkg::data_t extend_ref(id_pkg::imm16_t imm, logic sign);
    if (sign) begin
        return id_pkg::data_t'($signed(imm));
    end
    return id_pkg::data_t'(imm);
endfunction

// branch unit expectation, register values come from the mirror
function automatic void branch_ref(input id_pkg::data_t instr, input id_pkg::data_t pc4,
                                   output logic jump, output id_pkg::jump_case_t jcase,
                                   output id_pkg::data_t addr);
    ctl_ref_t      c;
    id_pkg::data_t rs_val;
    id_pkg::data_t rt_val;
    logic          taken;
    c = decode_ref(instr[31:26], instr[5:0]);
    rs_val = mirror[instr[25:21]];
    rt_val = mirror[instr[20:16]];
    taken = c.branch && ((rs_val == rt_val) != c.branch_ne);
    jcase = c.branch ? 2'd1 : (c.link ? 2'd2 : 2'd0);
    jump = c.jump_reg || c.jump || taken;
    if (c.jump_reg) begin
        addr = rs_val;
    end else if (c.jump) begin
        addr = {pc4[31:28], instr[25:0], 2'b00};
    end else if (taken) begin
        addr = pc4 + 32'd4 + extend_ref(instr[15:0], c.imm_sign) * 4;
    end else begin
        addr = '0;
    end
endfunction

`endif

//--- dv/id_stage_tb.sv
`include "id_settings.svh"

module id_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES = 3000;
    localparam int MAX_CYCLES = NUM_CYCLES + 50;

    `include "id_stage_model.svh"

    // expected contents of the ID/EX register
    typedef struct packed {
        id_pkg::data_t     reg_da;
        id_pkg::data_t     reg_db;
        id_pkg::data_t     immediate;
        id_pkg::reg_addr_t rs;
        id_pkg::reg_addr_t rt;
        id_pkg::reg_addr_t rd;
        id_pkg::opcode_t   opcode;
        id_pkg::shamt_t    shamt;
        id_pkg::funct_t    func;
        ctl_ref_t          ctl;
    } pipe_ref_t;

    logic clk;
    logic i_rst_n;
    logic i_we;
    logic i_stall;
    logic i_halt;
    id_pkg::data_t i_instruction;
    id_pkg::data_t i_pcounter4;
    id_pkg::reg_addr_t i_wr_addr;
    id_pkg::data_t i_wr_data;
    id_pkg::data_t o_reg_da;
    id_pkg::data_t o_reg_db;
    id_pkg::data_t o_immediate;
    id_pkg::data_t o_addr2jump;
    id_pkg::reg_addr_t o_rs;
    id_pkg::reg_addr_t o_rt;
    id_pkg::reg_addr_t o_rd;
    id_pkg::opcode_t o_opcode;
    id_pkg::shamt_t o_shamt;
    id_pkg::funct_t o_func;
    logic o_reg_dst;
    logic o_mem_to_reg;
    logic o_mem_read;
    logic o_mem_write;
    logic o_imm_sign;
    logic o_reg_write;
    logic o_branch;
    logic o_jump;
    logic o_stop;
    id_pkg::alu_src_t o_alu_src;
    id_pkg::alu_op_t o_alu_op;
    id_pkg::jump_case_t o_jump_cases;

    int errors;
    pipe_ref_t exp_pipe;

    id_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // upper bound on the run length
    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic data_cmp(string name, id_pkg::data_t exp, id_pkg::data_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic addr_cmp(string name, id_pkg::reg_addr_t exp, id_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic src_cmp(string name, id_pkg::alu_src_t exp, id_pkg::alu_src_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic aluop_cmp(string name, id_pkg::alu_op_t exp, id_pkg::alu_op_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic case_cmp(string name, id_pkg::jump_case_t exp, id_pkg::jump_case_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic flag_cmp(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic opcode_cmp(string name, id_pkg::opcode_t exp, id_pkg::opcode_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic shamt_cmp(string name, id_pkg::shamt_t exp, id_pkg::shamt_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic funct_cmp(string name, id_pkg::funct_t exp, id_pkg::funct_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic pipe_ref_t capture_ref(id_pkg::data_t instr, id_pkg::data_t pc4,
                                              logic stall);
        pipe_ref_t p;
        ctl_ref_t  c;
        c = decode_ref(instr[31:26], instr[5:0]);
        p.reg_da    = c.link ? pc4 : mirror[instr[25:21]];
        p.reg_db    = c.link ? `ID_LINK_OFFSET : mirror[instr[20:16]];
        p.immediate = extend_ref(instr[15:0], c.imm_sign);
        p.rs        = c.link ? 5'd0 : instr[25:21];
        p.rt        = (c.link && !c.reg_dst) ? `ID_LINK_REG : instr[20:16];
        p.rd        = instr[15:11];
        p.opcode    = instr[31:26];
        p.shamt     = instr[10:6];
        p.func      = instr[5:0];
        // a stalled slot becomes a bubble
        p.ctl       = stall ? ctl_ref_t'(0) : c;
        return p;
    endfunction

    task automatic pipe_check(pipe_ref_t e);
        data_cmp("o_reg_da", e.reg_da, o_reg_da);
        data_cmp("o_reg_db", e.reg_db, o_reg_db);
        data_cmp("o_immediate", e.immediate, o_immediate);
        addr_cmp("o_rs", e.rs, o_rs);
        addr_cmp("o_rt", e.rt, o_rt);
        addr_cmp("o_rd", e.rd, o_rd);
        opcode_cmp("o_opcode", e.opcode, o_opcode);
        shamt_cmp("o_shamt", e.shamt, o_shamt);
        funct_cmp("o_func", e.func, o_func);
        flag_cmp("o_reg_dst", e.ctl.reg_dst, o_reg_dst);
        flag_cmp("o_mem_to_reg", e.ctl.mem_to_reg, o_mem_to_reg);
        flag_cmp("o_mem_read", e.ctl.mem_read, o_mem_read);
        flag_cmp("o_mem_write", e.ctl.mem_write, o_mem_write);
        flag_cmp("o_imm_sign", e.ctl.imm_sign, o_imm_sign);
        flag_cmp("o_reg_write", e.ctl.reg_write, o_reg_write);
        flag_cmp("o_branch", e.ctl.branch, o_branch);
        src_cmp("o_alu_src", e.ctl.alu_src, o_alu_src);
        aluop_cmp("o_alu_op", e.ctl.alu_op, o_alu_op);
    endtask

    task automatic combo_check();
        logic               exp_jump;
        id_pkg::jump_case_t exp_case;
        id_pkg::data_t      exp_addr;
        branch_ref(i_instruction, i_pcounter4, exp_jump, exp_case, exp_addr);
        flag_cmp("o_jump", exp_jump, o_jump);
        case_cmp("o_jump_cases", exp_case, o_jump_cases);
        data_cmp("o_addr2jump", exp_addr, o_addr2jump);
        // stop word has every bit set
        flag_cmp("o_stop", &i_instruction, o_stop);
    endtask

    // expectations use the mirror before this cycle's write lands
    task automatic advance_model();
        if (!i_halt) begin
            exp_pipe = capture_ref(i_instruction, i_pcounter4, i_stall);
        end
        if (i_we && (i_wr_addr != 5'd0)) begin
            mirror[i_wr_addr] = i_wr_data;
        end
    endtask

    function automatic id_pkg::data_t random_instr();
        id_pkg::data_t w;
        int            kind;
        w = $urandom;
        kind = $urandom_range(0, 12);
        case (kind)
            0: w[31:26] = `ID_OPC_RTYPE;
            1: {w[31:26], w[5:0]} = {`ID_OPC_RTYPE, `ID_FN_JR};
            2: {w[31:26], w[5:0]} = {`ID_OPC_RTYPE, `ID_FN_JALR};
            3: w[31:26] = `ID_OPC_JAL;
            4: w[31:26] = `ID_OPC_J;
            5: w[31:26] = `ID_OPC_ADDI;
            6: w[31:26] = `ID_OPC_ORI;
            7: w[31:26] = `ID_OPC_LW;
            8: w[31:26] = `ID_OPC_SW;
            9: w[31:26] = `ID_OPC_BEQ;
            10: w[31:26] = `ID_OPC_BNE;
            // 44..63 holds no kept opcode
            11: w[31:26] = 6'd44 + 6'($urandom_range(0, 19));
            default: w = `ID_HALT_WORD;
        endcase
        // equal operands so that branches get taken too
        if ((kind == 9 || kind == 10) && $urandom_range(0, 1) == 1) begin
            w[20:16] = w[25:21];
        end
        return w;
    endfunction

    task automatic drive_random();
        id_pkg::data_t pc4;
        pc4 = $urandom;
        pc4[1:0] = 2'b00;
        i_instruction <= random_instr();
        i_pcounter4   <= pc4;
        i_we          <= $urandom_range(0, 1);
        i_wr_addr     <= id_pkg::reg_addr_t'($urandom);
        i_wr_data     <= $urandom;
        i_stall       <= ($urandom_range(0, 9) == 0);
        i_halt        <= ($urandom_range(0, 9) == 0);
    endtask

    task automatic apply_reset();
        i_rst_n       = 1'b0;
        i_we          = 1'b0;
        i_stall       = 1'b0;
        i_halt        = 1'b0;
        i_instruction = '0;
        i_pcounter4   = '0;
        i_wr_addr     = '0;
        i_wr_data     = '0;
        for (int i = 0; i < `ID_NUM_REGS; i++) begin
            mirror[i] = '0;
        end
        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;
    endtask

    initial begin
        errors = 0;
        void'($urandom(2));
        apply_reset();
        @(negedge clk);
        pipe_check(pipe_ref_t'(0));
        advance_model();
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            combo_check();
            pipe_check(exp_pipe);
            advance_model();
        end
        $display("Finished %0d cycles with %0d errors", NUM_CYCLES, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- id_stage.f
+incdir+common
+incdir+dv
common/id_pkg.sv
common/ctrl_if.sv
source/reg_file.sv
decode/ctrl_decoder.sv
decode/branch_unit.sv
source/id_ex_reg.sv
source/id_stage.sv
dv/id_stage_tb.sv

//--- source/id_ex_reg.sv
`include "id_settings.svh"

module id_ex_reg (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_stall,
    input  logic              i_halt,
    input  id_pkg::data_t     i_pcounter4,
    input  id_pkg::data_t     i_rs_data,
    input  id_pkg::data_t     i_rt_data,
    input  id_pkg::reg_addr_t i_rs,
    input  id_pkg::reg_addr_t i_rt,
    input  id_pkg::reg_addr_t i_rd,
    input  id_pkg::opcode_t   i_opcode,
    input  id_pkg::shamt_t    i_shamt,
    input  id_pkg::funct_t    i_funct,
    ctrl_if.pipe              ctrl,
    output id_pkg::data_t     o_reg_da,
    output id_pkg::data_t     o_reg_db,
    output id_pkg::data_t     o_immediate,
    output id_pkg::reg_addr_t o_rs,
    output id_pkg::reg_addr_t o_rt,
    output id_pkg::reg_addr_t o_rd,
    output id_pkg::opcode_t   o_opcode,
    output id_pkg::shamt_t    o_shamt,
    output id_pkg::funct_t    o_func,
    output logic              o_reg_dst,
    output logic              o_mem_to_reg,
    output logic              o_mem_read,
    output logic              o_mem_write,
    output logic              o_imm_sign,
    output logic              o_reg_write,
    output logic              o_branch,
    output id_pkg::alu_src_t  o_alu_src,
    output id_pkg::alu_op_t   o_alu_op
);

    // data fields, link values replace operands for jal/jalr
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_da    <= '0;
            o_reg_db    <= '0;
            o_immediate <= '0;
            o_rs        <= '0;
            o_rt        <= '0;
            o_rd        <= '0;
            o_opcode    <= '0;
            o_shamt     <= '0;
            o_func      <= '0;
        end else if (!i_halt) begin
            o_reg_da    <= ctrl.link ? i_pcounter4 : i_rs_data;
            o_reg_db    <= ctrl.link ? `ID_LINK_OFFSET : i_rt_data;
            o_rs        <= ctrl.link ? '0 : i_rs;
            // jal has no rd, it always writes the link register
            o_rt        <= (ctrl.link && !ctrl.reg_dst) ? `ID_LINK_REG : i_rt;
            o_rd        <= i_rd;
            o_immediate <= ctrl.imm;
            o_opcode    <= i_opcode;
            o_shamt     <= i_shamt;
            o_func      <= i_funct;
        end
    end

    // control fields, bubble on stall
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg_dst    <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_imm_sign   <= 1'b0;
            o_reg_write  <= 1'b0;
            o_branch     <= 1'b0;
            o_alu_src    <= '0;
            o_alu_op     <= '0;
        end else if (!i_halt) begin
            o_reg_dst    <= !i_stall && ctrl.reg_dst;
            o_mem_to_reg <= !i_stall && ctrl.mem_to_reg;
            o_mem_read   <= !i_stall && ctrl.mem_read;
            o_mem_write  <= !i_stall && ctrl.mem_write;
            o_imm_sign   <= !i_stall && ctrl.imm_sign;
            o_reg_write  <= !i_stall && ctrl.reg_write;
            o_branch     <= !i_stall && ctrl.branch;
            o_alu_src    <= i_stall ? id_pkg::ALU_SRC_REG : ctrl.alu_src;
            o_alu_op     <= i_stall ? id_pkg::ALU_OP_ADD : ctrl.alu_op;
        end
    end

endmodule

//--- source/id_stage.sv
`include "id_settings.svh"

module id_stage (
    input  logic                clk,
    input  logic                i_rst_n,
    input  id_pkg::data_t       i_instruction,
    input  id_pkg::data_t       i_pcounter4,
    input  logic                i_we,
    input  id_pkg::reg_addr_t   i_wr_addr,
    input  id_pkg::data_t       i_wr_data,
    input  logic                i_stall,
    input  logic                i_halt,
    output id_pkg::data_t       o_reg_da,
    output id_pkg::data_t       o_reg_db,
    output id_pkg::data_t       o_immediate,
    output id_pkg::reg_addr_t   o_rs,
    output id_pkg::reg_addr_t   o_rt,
    output id_pkg::reg_addr_t   o_rd,
    output id_pkg::opcode_t     o_opcode,
    output id_pkg::shamt_t      o_shamt,
    output id_pkg::funct_t      o_func,
    output logic                o_reg_dst,
    output logic                o_mem_to_reg,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_imm_sign,
    output logic                o_reg_write,
    output logic                o_branch,
    output id_pkg::alu_src_t    o_alu_src,
    output id_pkg::alu_op_t     o_alu_op,
    output logic                o_jump,
    output id_pkg::jump_case_t  o_jump_cases,
    output id_pkg::data_t       o_addr2jump,
    output logic                o_stop
);

    id_pkg::opcode_t   opcode;
    id_pkg::reg_addr_t rs;
    id_pkg::reg_addr_t rt;
    id_pkg::reg_addr_t rd;
    id_pkg::shamt_t    shamt;
    id_pkg::funct_t    funct;
    id_pkg::imm16_t    imm16;
    id_pkg::target_t   target;
    id_pkg::data_t     rs_data;
    id_pkg::data_t     rt_data;

    // instruction field split
    assign opcode = i_instruction[31:26];
    assign rs     = i_instruction[25:21];
    assign rt     = i_instruction[20:16];
    assign rd     = i_instruction[15:11];
    assign shamt  = i_instruction[10:6];
    assign funct  = i_instruction[5:0];
    assign imm16  = i_instruction[15:0];
    assign target = i_instruction[25:0];

    // last word of the program
    assign o_stop = (i_instruction == `ID_HALT_WORD);

    ctrl_if u_ctrl ();

    reg_file u_reg_file (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_we        (i_we),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .i_rd_addr_a (rs),
        .i_rd_addr_b (rt),
        .o_rd_data_a (rs_data),
        .o_rd_data_b (rt_data)
    );

    ctrl_decoder u_ctrl_decoder (
        .i_opcode (opcode),
        .i_funct  (funct),
        .i_imm    (imm16),
        .ctrl     (u_ctrl)
    );

    branch_unit u_branch_unit (
        .i_pcounter4  (i_pcounter4),
        .i_target     (target),
        .i_rs_data    (rs_data),
        .i_rt_data    (rt_data),
        .ctrl         (u_ctrl),
        .o_jump       (o_jump),
        .o_jump_cases (o_jump_cases),
        .o_addr2jump  (o_addr2jump)
    );

    id_ex_reg u_id_ex_reg (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_stall      (i_stall),
        .i_halt       (i_halt),
        .i_pcounter4  (i_pcounter4),
        .i_rs_data    (rs_data),
        .i_rt_data    (rt_data),
        .i_rs         (rs),
        .i_rt         (rt),
        .i_rd         (rd),
        .i_opcode     (opcode),
        .i_shamt      (shamt),
        .i_funct      (funct),
        .ctrl         (u_ctrl),
        .o_reg_da     (o_reg_da),
        .o_reg_db     (o_reg_db),
        .o_immediate  (o_immediate),
        .o_rs         (o_rs),
        .o_rt         (o_rt),
        .o_rd         (o_rd),
        .o_opcode     (o_opcode),
        .o_shamt      (o_shamt),
        .o_func       (o_func),
        .o_reg_dst    (o_reg_dst),
        .o_mem_to_reg (o_mem_to_reg),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_imm_sign   (o_imm_sign),
        .o_reg_write  (o_reg_write),
        .o_branch     (o_branch),
        .o_alu_src    (o_alu_src),
        .o_alu_op     (o_alu_op)
    );

endmodule

//--- source/reg_file.sv
`include "id_settings.svh"

module reg_file (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_we,
    input  id_pkg::reg_addr_t i_wr_addr,
    input  id_pkg::data_t     i_wr_data,
    input  id_pkg::reg_addr_t i_rd_addr_a,
    input  id_pkg::reg_addr_t i_rd_addr_b,
    output id_pkg::data_t     o_rd_data_a,
    output id_pkg::data_t     o_rd_data_b
);

    id_pkg::data_t regs [`ID_NUM_REGS];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `ID_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            // r0 is never written
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // no bypass, same-cycle write shows after the edge
    assign o_rd_data_a = regs[i_rd_addr_a];
    assign o_rd_data_b = regs[i_rd_addr_b];

endmodule
